// ==== build.f ====
logic/cache_pkg.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_controller.sv
logic/data_cache.sv
testbench/data_cache_asserts.sv
testbench/tb_data_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the data cache testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_data_cache -o sim_data_cache \
    > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_data_cache > sim.log 2>&1 && cat sim.log \
    || { cat sim.log; echo "simulation ended abnormally"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== testbench/tb_data_cache.sv ====
`timescale 1ns/1ns

module tb_data_cache;

    localparam int clk_period      = 8;
    localparam int test_count      = 6;
    localparam int cycles_per_test = 200;
    localparam int access_limit    = 100;
    localparam int watchdog_ns     = clk_period * cycles_per_test * test_count;
    localparam int la_bits         = $bits(cache_pkg::line_addr_t);

    logic                  clk;
    logic                  rst_n;
    logic                  load_valid;
    logic                  store_valid;
    cache_pkg::addr_t      addr;
    cache_pkg::word_t      store_data;
    logic                  mem_ack = 1'b0;
    cache_pkg::line_t      mem_rdata = '0;
    cache_pkg::word_t      load_data;
    logic                  done;
    logic                  busy;
    logic                  load_miss;
    logic                  store_miss;
    logic                  mem_req;
    logic                  mem_we;
    cache_pkg::line_addr_t mem_addr;
    cache_pkg::line_t      mem_wdata;

    // memory model holds one entry per line written back
    cache_pkg::line_t      mem_lines [cache_pkg::line_addr_t];
    cache_pkg::line_t      last_wb_data = '0;
    // each transfer as {we, line address}
    logic [la_bits:0]      traffic [$];
    int                    read_count = 0;
    int                    write_count = 0;
    int                    wait_count = 0;
    int                    ack_delay = 0;
    logic                  random_delay = 1'b0;

    // cpu stores seen so far
    cache_pkg::word_t      shadow [cache_pkg::addr_t];
    logic [31:0]           lcg_state = 32'd20;
    int                    error_count = 0;
    int                    tests_run = 0;

    data_cache data_cache_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .store_valid (store_valid),
        .addr        (addr),
        .store_data  (store_data),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .load_data   (load_data),
        .done        (done),
        .busy        (busy),
        .load_miss   (load_miss),
        .store_miss  (store_miss),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // upper half since the low bits of an lcg cycle quickly
        return {16'h0000, lcg_state[31:16]};
    endfunction

    // untouched memory word is its own byte address xor a key
    function automatic cache_pkg::line_t pattern_line(input cache_pkg::line_addr_t la);
        cache_pkg::line_t line;
        cache_pkg::addr_t byte_addr;
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            byte_addr = {la, 4'b0000} + cache_pkg::addr_t'(4 * i);
            line[32*i +: 32] = byte_addr ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic value_error(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, error_count - errs_before);
    endtask

    // --------------------------------------------------
    // memory model
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ack    <= 1'b0;
            wait_count <= 0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_req) begin
            if (wait_count >= ack_delay) begin
                mem_ack    <= 1'b1;
                wait_count <= 0;
                if (mem_we) begin
                    mem_lines[mem_addr] = mem_wdata;
                    last_wb_data = mem_wdata;
                    write_count++;
                    traffic.push_back({1'b1, mem_addr});
                end else begin
                    mem_rdata <= mem_lines.exists(mem_addr) ? mem_lines[mem_addr]
                                                            : pattern_line(mem_addr);
                    read_count++;
                    traffic.push_back({1'b0, mem_addr});
                end
                if (random_delay) begin
                    ack_delay <= int'(next_random() % 4);
                end
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

    // --------------------------------------------------
    // cpu access that waits for done
    // --------------------------------------------------
    task automatic access(input logic is_store, input cache_pkg::addr_t a,
                          input cache_pkg::word_t d, output cache_pkg::word_t rdata,
                          output int misses);
        int   cycles;
        logic finished;
        logic prev_req;
        logic prev_ack;
        rdata    = '0;
        misses   = 0;
        cycles   = 0;
        finished = 1'b0;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        @(posedge clk);
        load_valid  <= !is_store;
        store_valid <= is_store;
        addr        <= a;
        store_data  <= d;
        @(posedge clk);
        load_valid  <= 1'b0;
        store_valid <= 1'b0;
        while (!finished && cycles < access_limit) begin
            @(negedge clk);
            cycles++;
            if ((load_miss && is_store) || (store_miss && !is_store)) begin
                report_failure("miss strobe of the wrong kind");
            end
            if (load_miss || store_miss) begin
                misses++;
            end
            if (prev_req && !prev_ack && !mem_req) begin
                report_failure("mem_req dropped before mem_ack");
            end
            prev_req = mem_req;
            prev_ack = mem_ack;
            if (!busy) begin
                report_failure("busy dropped before done");
                finished = 1'b1;
            end else if (done) begin
                rdata    = load_data;
                finished = 1'b1;
            end
        end
        if (!finished) begin
            report_failure("no done within the access limit");
        end
        if (is_store) begin
            shadow[a] = d;
        end
    endtask

    task automatic load_check(input cache_pkg::addr_t a, input int exp_misses);
        cache_pkg::word_t got;
        int               misses;
        access(1'b0, a, '0, got, misses);
        if (got !== expected_word(a)) begin
            value_error("load_data", expected_word(a), got);
        end
        if (misses != exp_misses) begin
            value_error("load_miss pulses", exp_misses, misses);
        end
    endtask

    task automatic store_check(input cache_pkg::addr_t a, input cache_pkg::word_t d,
                               input int exp_misses);
        cache_pkg::word_t got;
        int               misses;
        access(1'b1, a, d, got, misses);
        if (misses != exp_misses) begin
            value_error("store_miss pulses", exp_misses, misses);
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        int errs_before;
        int reads_before;
        errs_before = error_count;
        @(negedge clk);
        if ({busy, done, load_miss, store_miss, mem_req} !== 5'b00000) begin
            value_error("busy/done/load_miss/store_miss/mem_req", 0,
                        {busy, done, load_miss, store_miss, mem_req});
        end
        reads_before = read_count;
        load_check(32'h0000_1004, 1);
        if (read_count - reads_before != 1) begin
            value_error("memory reads", 1, read_count - reads_before);
        end
        finish_test("reset and first load", errs_before);
    endtask

    task automatic test_load_hit();
        int errs_before;
        int t0;
        errs_before = error_count;
        t0 = traffic.size();
        load_check(32'h0000_2010, 1);
        if (traffic.size() - t0 != 1) begin
            value_error("memory transfers", 1, traffic.size() - t0);
        end else if (traffic[t0] !== {1'b0, 28'h000_0201}) begin
            value_error("read line", {1'b0, 28'h000_0201}, traffic[t0]);
        end
        t0 = traffic.size();
        load_check(32'h0000_2018, 0);
        if (traffic.size() != t0) begin
            value_error("memory transfers", 0, traffic.size() - t0);
        end
        finish_test("load miss then hit", errs_before);
    endtask

    task automatic test_store_miss();
        int errs_before;
        errs_before = error_count;
        store_check(32'h0000_3024, 32'hDEAD_BEEF, 1);
        load_check(32'h0000_3024, 0);
        load_check(32'h0000_3028, 0);
        finish_test("store miss and refill", errs_before);
    endtask

    task automatic test_dirty_eviction();
        int               errs_before;
        int               t0;
        cache_pkg::addr_t a_addr;
        cache_pkg::addr_t c_addr;
        cache_pkg::line_t exp_line;
        errs_before = error_count;
        a_addr = 32'h0000_4034;
        c_addr = 32'h0000_4230;
        store_check(a_addr, 32'h1234_5678, 1);
        load_check(32'h0000_4130, 1);
        t0 = traffic.size();
        load_check(c_addr, 1);
        if (traffic.size() - t0 != 2) begin
            value_error("memory transfers", 2, traffic.size() - t0);
        end else begin
            if (traffic[t0] !== {1'b1, a_addr[31:4]}) begin
                value_error("writeback line", {1'b1, a_addr[31:4]}, traffic[t0]);
            end
            if (traffic[t0+1] !== {1'b0, c_addr[31:4]}) begin
                value_error("refill line", {1'b0, c_addr[31:4]}, traffic[t0+1]);
            end
        end
        // stored word sits in word 1 of line A
        exp_line = pattern_line(a_addr[31:4]);
        exp_line[32 +: 32] = 32'h1234_5678;
        if (last_wb_data !== exp_line) begin
            value_error("mem_wdata", exp_line, last_wb_data);
        end
        load_check(a_addr, 1);
        finish_test("dirty eviction", errs_before);
    endtask

    task automatic test_lru_order();
        int errs_before;
        int writes_before;
        int t0;
        errs_before   = error_count;
        writes_before = write_count;
        load_check(32'h0000_5040, 1);
        load_check(32'h0000_5140, 1);
        load_check(32'h0000_5040, 0);
        t0 = traffic.size();
        load_check(32'h0000_5240, 1);
        if (traffic.size() - t0 != 1) begin
            value_error("memory transfers", 1, traffic.size() - t0);
        end else if (traffic[t0] !== {1'b0, 28'h000_0524}) begin
            value_error("read line", {1'b0, 28'h000_0524}, traffic[t0]);
        end
        t0 = traffic.size();
        load_check(32'h0000_5040, 0);
        if (traffic.size() != t0) begin
            value_error("memory transfers", 0, traffic.size() - t0);
        end
        load_check(32'h0000_5140, 1);
        // only clean lines are evicted here
        if (write_count != writes_before) begin
            value_error("memory writes", 0, write_count - writes_before);
        end
        finish_test("lru order", errs_before);
    endtask

    task automatic test_random_traffic();
        int               errs_before;
        logic [31:0]      r;
        int               tag_sel;
        int               set_sel;
        int               word_sel;
        cache_pkg::addr_t a;
        cache_pkg::word_t d;
        cache_pkg::word_t got;
        int               misses;
        errs_before = error_count;
        random_delay = 1'b1;
        for (int n = 0; n < 30; n++) begin
            r = next_random();
            // four tags over sets 5 to 7
            tag_sel  = int'(r % 4);
            set_sel  = 5 + int'((r >> 2) % 3);
            word_sel = int'((r >> 5) % 4);
            a = cache_pkg::addr_t'(32'h6000 + tag_sel * 256 + set_sel * 16 + word_sel * 4);
            if (r[9]) begin
                d = (next_random() << 16) | r;
                access(1'b1, a, d, got, misses);
            end else begin
                access(1'b0, a, '0, got, misses);
                if (got !== expected_word(a)) begin
                    value_error("load_data", expected_word(a), got);
                end
            end
        end
        random_delay = 1'b0;
        finish_test("random traffic with ack delays", errs_before);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        load_valid  = 1'b0;
        store_valid = 1'b0;
        addr        = '0;
        store_data  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_load_hit();
        test_store_miss();
        test_dirty_eviction();
        test_lru_order();
        test_random_traffic();
        $display("tests run %0d, errors %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not complete", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== testbench/data_cache_asserts.sv ====
`timescale 1ns/1ns

module data_cache_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  load_valid,
    input logic                  store_valid,
    input logic                  done,
    input logic                  busy,
    input logic                  load_miss,
    input logic                  store_miss,
    input logic                  mem_req,
    input logic                  mem_ack,
    input cache_pkg::line_addr_t mem_addr
);

    // done only ends a request that was already busy
    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(busy))
        else $error("done without busy in the previous cycle");

    // memory request held with a stable address until acknowledged
    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)))
        else $error("mem_req or mem_addr changed before mem_ack");

    miss_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_miss && store_miss))
        else $error("load_miss and store_miss high together");

    // cpu waits on busy
    no_strobe_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (load_valid || store_valid) |-> !busy)
        else $error("request strobe while busy");

endmodule

bind data_cache data_cache_asserts data_cache_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_valid  (load_valid),
    .store_valid (store_valid),
    .done        (done),
    .busy        (busy),
    .load_miss   (load_miss),
    .store_miss  (store_miss),
    .mem_req     (mem_req),
    .mem_ack     (mem_ack),
    .mem_addr    (mem_addr)
);

// ==== logic/data_cache.sv ====
`timescale 1ns/1ns

module data_cache #(
    parameter int num_sets = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_valid,
    input  logic                  store_valid,
    input  cache_pkg::addr_t      addr,
    input  cache_pkg::word_t      store_data,
    input  logic                  mem_ack,
    input  cache_pkg::line_t      mem_rdata,
    output cache_pkg::word_t      load_data,
    output logic                  done,
    output logic                  busy,
    output logic                  load_miss,
    output logic                  store_miss,
    output logic                  mem_req,
    output logic                  mem_we,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata
);

    // --------------------------------------------------
    // controller to array wiring
    // --------------------------------------------------
    logic [$clog2(num_sets)-1:0]                  index;
    cache_pkg::line_addr_t                        lookup_tag;
    logic [$clog2(cache_pkg::words_per_line)-1:0] word_sel;
    logic                                         tag_we;
    cache_pkg::way_t                              tag_we_way;
    logic                                         store_we;
    cache_pkg::way_t                              store_way;
    logic                                         line_we;
    cache_pkg::line_t                             fill_line;
    cache_pkg::way_t                              touch_way;
    logic                                         touch;

    // array results
    logic                  hit;
    cache_pkg::way_t       hit_way;
    cache_pkg::way_t       victim_way;
    logic                  victim_dirty;
    cache_pkg::line_addr_t victim_tag;
    cache_pkg::line_t      rd_line;

    cache_controller #(
        .num_sets (num_sets)
    ) cache_controller_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_valid   (load_valid),
        .store_valid  (store_valid),
        .addr         (addr),
        .store_data   (store_data),
        .load_data    (load_data),
        .done         (done),
        .busy         (busy),
        .load_miss    (load_miss),
        .store_miss   (store_miss),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_line      (rd_line),
        .index        (index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .tag_we       (tag_we),
        .tag_we_way   (tag_we_way),
        .store_we     (store_we),
        .store_way    (store_way),
        .line_we      (line_we),
        .fill_line    (fill_line),
        .touch_way    (touch_way),
        .touch        (touch)
    );

    cache_tag_array #(
        .num_sets (num_sets)
    ) cache_tag_array_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (index),
        .lookup_tag   (lookup_tag),
        .tag_we       (tag_we),
        .tag_we_way   (tag_we_way),
        .store_we     (store_we),
        .store_way    (store_way),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // store word rides in the low slot of fill_line
    // read way follows touch_way
    cache_data_array #(
        .num_sets (num_sets)
    ) cache_data_array_inst (
        .clk        (clk),
        .index      (index),
        .word_sel   (word_sel),
        .store_we   (store_we),
        .store_way  (store_way),
        .store_data (fill_line[$bits(cache_pkg::word_t)-1:0]),
        .line_we    (line_we),
        .tag_we_way (tag_we_way),
        .fill_line  (fill_line),
        .hit_way    (touch_way),
        .rd_line    (rd_line)
    );

endmodule

// ==== logic/cache_controller.sv ====
`timescale 1ns/1ns

module cache_controller #(
    parameter int num_sets = 16
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    // cpu side
    input  logic                                         load_valid,
    input  logic                                         store_valid,
    input  cache_pkg::addr_t                             addr,
    input  cache_pkg::word_t                             store_data,
    output cache_pkg::word_t                             load_data,
    output logic                                         done,
    output logic                                         busy,
    output logic                                         load_miss,
    output logic                                         store_miss,
    // memory side
    output logic                                         mem_req,
    output logic                                         mem_we,
    output cache_pkg::line_addr_t                        mem_addr,
    output cache_pkg::line_t                             mem_wdata,
    input  logic                                         mem_ack,
    input  cache_pkg::line_t                             mem_rdata,
    // tag array
    input  logic                                         hit,
    input  cache_pkg::way_t                              hit_way,
    input  cache_pkg::way_t                              victim_way,
    input  logic                                         victim_dirty,
    input  cache_pkg::line_addr_t                        victim_tag,
    // data array
    input  cache_pkg::line_t                             rd_line,
    // array control
    output logic [$clog2(num_sets)-1:0]                  index,
    output cache_pkg::line_addr_t                        lookup_tag,
    output logic [$clog2(cache_pkg::words_per_line)-1:0] word_sel,
    output logic                                         tag_we,
    output cache_pkg::way_t                              tag_we_way,
    output logic                                         store_we,
    output cache_pkg::way_t                              store_way,
    output logic                                         line_we,
    output cache_pkg::line_t                             fill_line,
    output cache_pkg::way_t                              touch_way,
    output logic                                         touch
);

    localparam int index_bits = $clog2(num_sets);
    localparam int sel_bits   = $clog2(cache_pkg::words_per_line);
    localparam int word_bits  = $bits(cache_pkg::word_t);

    typedef enum logic [2:0] {
        idle,
        lookup,
        writeback,
        refill,
        respond
    } ctrl_state_t;

    ctrl_state_t           state;
    logic                  req_is_store;
    // set once a miss was reported for this request
    logic                  miss_seen;
    logic                  mem_req_q;
    logic                  refill_ack;
    cache_pkg::addr_t      req_addr;
    cache_pkg::word_t      req_data;
    cache_pkg::way_t       victim_way_q;
    cache_pkg::line_addr_t victim_tag_q;
    cache_pkg::word_t      load_data_q;

    // --------------------------------------------------
    // request decode
    // --------------------------------------------------
    assign index      = req_addr[cache_pkg::offset_bits +: index_bits];
    assign lookup_tag = req_addr[$bits(cache_pkg::addr_t)-1:cache_pkg::offset_bits];
    assign word_sel   = req_addr[cache_pkg::offset_bits-1 -: sel_bits];

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= idle;
            req_is_store <= 1'b0;
            miss_seen    <= 1'b0;
            mem_req_q    <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (load_valid || store_valid) begin
                        req_is_store <= store_valid;
                        miss_seen    <= 1'b0;
                        state        <= lookup;
                    end
                end
                lookup: begin
                    if (hit) begin
                        state <= respond;
                    end else begin
                        miss_seen <= 1'b1;
                        state     <= victim_dirty ? writeback : refill;
                    end
                end
                writeback, refill: begin
                    // raise the request, then hold it until the ack
                    if (!mem_req_q) begin
                        mem_req_q <= 1'b1;
                    end else if (mem_ack) begin
                        mem_req_q <= 1'b0;
                        state     <= (state == writeback) ? refill : lookup;
                    end
                end
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request payload and miss bookkeeping
    always_ff @(posedge clk) begin
        if (state == idle && (load_valid || store_valid)) begin
            req_addr <= addr;
            req_data <= store_data;
        end
        if (state == lookup) begin
            if (hit) begin
                load_data_q <= rd_line[word_sel*word_bits +: word_bits];
            end else begin
                victim_way_q <= victim_way;
                victim_tag_q <= victim_tag;
            end
        end
    end

    // --------------------------------------------------
    // cpu outputs
    // --------------------------------------------------
    assign busy       = (state != idle);
    assign done       = (state == respond);
    assign load_data  = load_data_q;
    assign load_miss  = (state == lookup) && !hit && !miss_seen && !req_is_store;
    assign store_miss = (state == lookup) && !hit && !miss_seen && req_is_store;

    // memory port
    assign mem_req    = mem_req_q;
    assign mem_we     = (state == writeback);
    assign mem_addr   = (state == writeback) ? victim_tag_q : lookup_tag;
    assign mem_wdata  = rd_line;

    // --------------------------------------------------
    // array control
    // --------------------------------------------------
    assign refill_ack = (state == refill) && mem_req_q && mem_ack;
    assign tag_we     = refill_ack;
    assign tag_we_way = victim_way_q;
    assign line_we    = refill_ack;

    // outside refill every word slot carries the store word
    assign fill_line  = (state == refill) ? mem_rdata
                                          : {cache_pkg::words_per_line{req_data}};

    assign store_we   = (state == lookup) && hit && req_is_store;
    assign store_way  = hit_way;
    assign touch      = (state == lookup) && hit;

    // also the read way of the data array
    assign touch_way  = (state == writeback) ? victim_way_q : hit_way;

endmodule

// ==== logic/cache_data_array.sv ====
`timescale 1ns/1ns

module cache_data_array #(
    parameter int num_sets = 16
) (
    input  logic                                         clk,
    input  logic [$clog2(num_sets)-1:0]                  index,
    input  logic [$clog2(cache_pkg::words_per_line)-1:0] word_sel,
    input  logic                                         store_we,
    input  cache_pkg::way_t                              store_way,
    input  cache_pkg::word_t                             store_data,
    input  logic                                         line_we,
    input  cache_pkg::way_t                              tag_we_way,
    input  cache_pkg::line_t                             fill_line,
    input  cache_pkg::way_t                              hit_way,
    output cache_pkg::line_t                             rd_line
);

    localparam int word_bits = $bits(cache_pkg::word_t);

    // --------------------------------------------------
    // line storage
    // --------------------------------------------------
    cache_pkg::line_t lines [num_sets][cache_pkg::num_ways];

    // whole line on refill, single word on store hit
    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[index][tag_we_way] <= fill_line;
        end else if (store_we) begin
            lines[index][store_way][word_sel*word_bits +: word_bits] <= store_data;
        end
    end

    // read port, way picked by the controller
    // hit way in lookup, victim way in writeback
    assign rd_line = lines[index][hit_way];

endmodule

// ==== logic/cache_tag_array.sv ====
`timescale 1ns/1ns

module cache_tag_array #(
    parameter int num_sets = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [$clog2(num_sets)-1:0]  index,
    input  cache_pkg::line_addr_t        lookup_tag,
    input  logic                         tag_we,
    input  cache_pkg::way_t              tag_we_way,
    input  logic                         store_we,
    input  cache_pkg::way_t              store_way,
    input  logic                         touch,
    input  cache_pkg::way_t              touch_way,
    output logic                         hit,
    output cache_pkg::way_t              hit_way,
    output cache_pkg::way_t              victim_way,
    output logic                         victim_dirty,
    output cache_pkg::line_addr_t        victim_tag
);

    // --------------------------------------------------
    // per set and way state
    // --------------------------------------------------
    cache_pkg::line_addr_t              tags  [num_sets][cache_pkg::num_ways];
    logic [cache_pkg::num_ways-1:0]     valid [num_sets];
    logic [cache_pkg::num_ways-1:0]     dirty [num_sets];
    // lru[s] names the least recently used way of set s
    logic [num_sets-1:0]                lru;
    logic [cache_pkg::num_ways-1:0]     way_hit;

    // valid, dirty and lru bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            lru <= '0;
        end else begin
            // refill installs a clean line
            if (tag_we) begin
                valid[index][tag_we_way] <= 1'b1;
                dirty[index][tag_we_way] <= 1'b0;
            end
            // store hit marks the line dirty
            if (store_we) begin
                dirty[index][store_way] <= 1'b1;
            end
            // the other way becomes LRU
            if (touch) begin
                lru[index] <= ~touch_way;
            end
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[index][tag_we_way] <= lookup_tag;
        end
    end

    // --------------------------------------------------
    // hit compare
    // --------------------------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            way_hit[w] = valid[index][w] && (tags[index][w] == lookup_tag);
            if (way_hit[w]) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // victim is always the LRU way of the set
    assign victim_way   = lru[index];
    assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];
    assign victim_tag   = tags[index][victim_way];

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // --------------------------------------------------
    // cache geometry
    // --------------------------------------------------
    // words in one cache line
    localparam int words_per_line = 4;
    // byte offset bits within a line
    localparam int offset_bits = 4;
    // fixed at two, one LRU bit per set
    localparam int num_ways = 2;

    // --------------------------------------------------
    // vector types
    // --------------------------------------------------
    // cpu data word
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // full line, word 0 in the low bits
    typedef logic [words_per_line*$bits(word_t)-1:0] line_t;

    // byte address without the line offset, also used as the stored tag
    typedef logic [$bits(addr_t)-offset_bits-1:0] line_addr_t;

    // way select
    typedef logic [0:0] way_t;

endpackage
